// File: dv/p4_app_tb.sv
module p4_app_tb
   import axis_pkg::*;
   import p4_app_pkg::*;
();

   localparam int WAIT_LIMIT = 200;
   localparam int MAX_CYCLES = 20000;

   logic        core_clk;
   logic        reset;
   reg_req_t    reg_req;
   logic        reg_req_valid;
   logic        reg_ack;
   logic [31:0] reg_rdata;
   logic        in_valid;
   axis_beat_t  in_beat;
   logic        in_ready;
   logic        out_valid;
   axis_out_t   out_beat;
   logic        out_ready;

   integer      seed = 32'h3481;
   int          value_errors = 0;
   int          other_errors = 0;
   bit          sink_random = 1'b0;

   // register model, raw register words
   logic [31:0] model_trunc = 32'h0;
   logic [31:0] model_rss   = 32'h0;
   logic [31:0] model_map   = 32'h0000_00e4;

   axis_out_t   expected_q[$];
   axis_out_t   exp_beat;
   axis_out_t   held_beat;
   bit          stalled;
   bit          in_packet;
   logic [15:0] pkt_pid;
   port_id_t    pkt_dest;

   p4_app p4_app_i (
      .core_clk      (core_clk),
      .reset         (reset),
      .reg_req       (reg_req),
      .reg_req_valid (reg_req_valid),
      .reg_ack       (reg_ack),
      .reg_rdata     (reg_rdata),
      .in_valid      (in_valid),
      .in_beat       (in_beat),
      .in_ready      (in_ready),
      .out_valid     (out_valid),
      .out_beat      (out_beat),
      .out_ready     (out_ready)
   );

   initial begin
      core_clk = 1'b0;
      forever #20 core_clk = ~core_clk;
   end

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------

   function automatic axis_out_t predict_beat(input axis_beat_t beat, input logic [15:0] pid,
                                              input logic [1:0] port, input logic [31:0] trunc_reg,
                                              input logic [31:0] rss_reg,
                                              input logic [31:0] map_reg);
      axis_out_t exp;
      exp = '0;
      exp.tdata = beat.tdata;
      exp.tkeep = beat.tkeep;
      exp.tlast = beat.tlast;
      exp.tdest = map_reg[2*port +: 2];
      exp.tuser.pid = pid;
      // metadata defaults are zero, so only an enabled override shows up
      if (trunc_reg[0]) begin
         exp.tuser.trunc_enable = trunc_reg[1];
         exp.tuser.trunc_length = trunc_reg[31:16];
      end
      if (rss_reg[0]) begin
         exp.tuser.rss_enable  = rss_reg[1];
         exp.tuser.rss_entropy = rss_reg[27:16];
      end
      return exp;
   endfunction

   function automatic logic [31:0] expected_reg(input logic [7:0] addr);
      case (addr)
         8'h00:   return model_trunc;
         8'h04:   return model_rss;
         8'h08:   return model_map;
         default: return 32'h0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic compare_beat(input axis_out_t got, input axis_out_t exp);
      check_value("out_beat.tdata", got.tdata, exp.tdata);
      check_value("out_beat.tkeep", got.tkeep, exp.tkeep);
      check_value("out_beat.tlast", got.tlast, exp.tlast);
      check_value("out_beat.tdest", got.tdest, exp.tdest);
      check_value("out_beat.tuser.pid", got.tuser.pid, exp.tuser.pid);
      check_value("out_beat.tuser.trunc_enable", got.tuser.trunc_enable,
                  exp.tuser.trunc_enable);
      check_value("out_beat.tuser.trunc_length", got.tuser.trunc_length,
                  exp.tuser.trunc_length);
      check_value("out_beat.tuser.rss_enable", got.tuser.rss_enable, exp.tuser.rss_enable);
      check_value("out_beat.tuser.rss_entropy", got.tuser.rss_entropy,
                  exp.tuser.rss_entropy);
   endtask

   // --------------------------------------------------
   // register port driver
   // --------------------------------------------------

   task automatic reg_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      int n;
      reg_req.addr  = addr;
      reg_req.wr    = wr;
      reg_req.wdata = wdata;
      reg_req_valid = 1'b1;
      n = 0;
      while (!reg_ack && n < WAIT_LIMIT) begin
         @(posedge core_clk);
         #2;
         n++;
      end
      rdata = reg_rdata;
      if (!reg_ack) begin
         other_errors++;
         $display("reg_ack never rose for address 0x%0h", addr);
      end else begin
         // ack has to stay up while req is held
         @(posedge core_clk);
         #2;
         check_value("reg_ack", reg_ack, 1'b1);
      end
      reg_req_valid = 1'b0;
      n = 0;
      while (reg_ack && n < WAIT_LIMIT) begin
         @(posedge core_clk);
         #2;
         n++;
      end
      if (reg_ack) begin
         other_errors++;
         $display("reg_ack did not fall after req was dropped");
      end
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      reg_access(addr, 1'b1, data, unused);
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
      reg_access(addr, 1'b0, 32'h0, data);
   endtask

   task automatic check_reg(input logic [7:0] addr);
      logic [31:0] rd;
      reg_read(addr, rd);
      check_value("reg_rdata", rd, expected_reg(addr));
   endtask

   // write, update the model with the implemented bits, read back
   task automatic write_config(input logic [7:0] addr, input logic [31:0] data);
      reg_write(addr, data);
      case (addr)
         8'h00:   model_trunc = data & 32'hffff_0003;
         8'h04:   model_rss   = data & 32'h0fff_0003;
         8'h08:   model_map   = data & 32'h0000_00ff;
         default: ;
      endcase
      check_reg(addr);
   endtask

   // --------------------------------------------------
   // packet source
   // --------------------------------------------------

   task automatic send_packet(input bit gaps);
      int          nbeats;
      int          i;
      int          n;
      bit          accepted;
      logic [31:0] rnd;
      logic [15:0] pid;
      logic [1:0]  port;
      axis_beat_t  beat;
      rnd    = $random(seed);
      nbeats = 1 + rnd[1:0];
      rnd    = $random(seed);
      pid    = rnd[15:0];
      port   = rnd[17:16];
      for (i = 0; i < nbeats; i++) begin
         beat.tdata = {$random(seed), $random(seed)};
         rnd        = $random(seed);
         beat.tkeep = rnd[7:0];
         beat.tlast = (i == nbeats - 1);
         // later beats carry junk id fields, only the first one counts
         if (i == 0) begin
            beat.tid = port;
            beat.pid = pid;
         end else begin
            beat.tid = rnd[9:8];
            beat.pid = rnd[31:16];
         end
         in_beat  = beat;
         in_valid = 1'b1;
         accepted = 1'b0;
         n = 0;
         while (!accepted && n < WAIT_LIMIT) begin
            @(posedge core_clk);
            accepted = in_ready;
            #2;
            n++;
         end
         in_valid = 1'b0;
         if (accepted) begin
            expected_q.push_back(predict_beat(beat, pid, port, model_trunc, model_rss,
                                              model_map));
         end else begin
            other_errors++;
            $display("in_ready stayed low, input beat was never accepted");
         end
         if (gaps) begin
            rnd = $random(seed);
            repeat (rnd[1:0] % 3) begin
               @(posedge core_clk);
               #2;
            end
         end
      end
   endtask

   task automatic send_packets(input int count, input bit gaps);
      repeat (count) send_packet(gaps);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (expected_q.size() != 0 && n < WAIT_LIMIT) begin
         @(posedge core_clk);
         #2;
         n++;
      end
      if (expected_q.size() != 0) begin
         other_errors++;
         $display("pipeline did not drain, %0d beats never came out", expected_q.size());
      end
   endtask

   task automatic finish_run();
      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   endtask

   // sink, ready is picked at the edge and driven just after it
   initial begin
      logic [31:0] rnd;
      logic        next_ready;
      out_ready = 1'b1;
      forever begin
         @(posedge core_clk);
         rnd        = $random(seed);
         next_ready = sink_random ? (rnd[1:0] != 2'b00) : 1'b1;
         #2;
         out_ready = next_ready;
      end
   end

   // --------------------------------------------------
   // comparer
   // --------------------------------------------------

   always @(posedge core_clk) begin
      if (reset) begin
         stalled   = 1'b0;
         in_packet = 1'b0;
      end else begin
         if (stalled) begin
            check_value("out_valid", out_valid, 1'b1);
            check_value("out_beat", out_beat, held_beat);
         end
         if (out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
               other_errors++;
               $display("output beat arrived while none was expected");
            end else begin
               exp_beat = expected_q.pop_front();
               compare_beat(out_beat, exp_beat);
            end
            if (in_packet) begin
               check_value("out_beat.tuser.pid", out_beat.tuser.pid, pkt_pid);
               check_value("out_beat.tdest", out_beat.tdest, pkt_dest);
            end else begin
               pkt_pid  = out_beat.tuser.pid;
               pkt_dest = out_beat.tdest;
            end
            in_packet = !out_beat.tlast;
         end
         stalled   = out_valid && !out_ready;
         held_beat = out_beat;
      end
   end

   initial begin
      repeat (MAX_CYCLES) @(posedge core_clk);
      other_errors++;
      $display("run went past its cycle limit");
      finish_run();
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   initial begin
      reset         = 1'b1;
      reg_req       = '0;
      reg_req_valid = 1'b0;
      in_valid      = 1'b0;
      in_beat       = '0;
      repeat (8) @(posedge core_clk);
      #2;
      reset = 1'b0;

      // reset values and plain pass-through
      check_reg(REG_TRUNC_CFG);
      check_reg(REG_RSS_CFG);
      check_reg(REG_PORT_MAP);
      send_packets(6, 1'b0);
      wait_drain();

      // reversed port map
      write_config(REG_PORT_MAP, 32'h0000_001b);
      send_packets(6, 1'b0);
      wait_drain();

      // truncation override on, then off with fields still set
      write_config(REG_TRUNC_CFG, 32'h05ee_0003);
      send_packets(6, 1'b0);
      wait_drain();
      write_config(REG_TRUNC_CFG, 32'h0400_0002);
      send_packets(4, 1'b0);
      wait_drain();

      // hash steering alone, then together with truncation
      write_config(REG_RSS_CFG, 32'h0abc_0003);
      send_packets(6, 1'b0);
      wait_drain();
      write_config(REG_TRUNC_CFG, 32'h0040_0001);
      send_packets(6, 1'b0);
      wait_drain();

      // back-pressure with gaps on the input side
      write_config(REG_PORT_MAP, 32'h0000_008d);
      write_config(REG_TRUNC_CFG, $random(seed));
      write_config(REG_RSS_CFG, $random(seed));
      sink_random = 1'b1;
      send_packets(40, 1'b1);
      wait_drain();
      sink_random = 1'b0;

      // unknown address is acknowledged, reads zero, changes nothing
      reg_write(8'h0c, 32'hffff_ffff);
      check_reg(8'h0c);
      check_reg(8'h40);
      check_reg(REG_TRUNC_CFG);
      check_reg(REG_RSS_CFG);
      check_reg(REG_PORT_MAP);
      send_packets(4, 1'b0);
      wait_drain();

      if (expected_q.size() != 0) begin
         other_errors++;
         $display("expected queue not empty at the end of the run");
      end
      finish_run();
   end

endmodule : p4_app_tb

// File: sim.f
src/axis_pkg.sv
src/p4_app_pkg.sv
src/p4_app_reg_blk.sv
src/meta_ingress.sv
src/egress_lookup.sv
src/meta_override.sv
src/p4_app.sv
dv/p4_app_tb.sv

// File: src/axis_pkg.sv
package axis_pkg;

   // --------------------------------------------------
   // switch side stream types
   // --------------------------------------------------

   // switch port number
   typedef logic [1:0] port_id_t;

   // one beat as it arrives from the switch
   // pid is only meaningful on the first beat of a packet
   typedef struct packed {
      logic [63:0] tdata;
      logic [7:0]  tkeep;
      logic        tlast;
      port_id_t    tid;
      logic [15:0] pid;
   } axis_beat_t;

   // user field sent back with every outgoing beat
   typedef struct packed {
      logic [15:0] pid;
      logic        trunc_enable;
      logic [15:0] trunc_length;
      logic        rss_enable;
      logic [11:0] rss_entropy;
   } egress_tuser_t;

   // one beat as it leaves towards the switch
   typedef struct packed {
      logic [63:0]   tdata;
      logic [7:0]    tkeep;
      logic          tlast;
      port_id_t      tdest;
      egress_tuser_t tuser;
   } axis_out_t;

endpackage : axis_pkg

// File: src/egress_lookup.sv
module egress_lookup
   import axis_pkg::*;
   import p4_app_pkg::*;
(
   input  logic       core_clk,
   input  logic       reset,
   input  port_map_t  port_map,
   input  logic       in_valid,
   input  meta_beat_t in_beat,
   input  logic       out_ready,
   output logic       in_ready,
   output logic       out_valid,
   output meta_beat_t out_beat
);

   logic     sop;
   logic     in_fire;
   port_id_t egress_new;
   port_id_t egress_q;
   port_id_t beat_egress;

   assign in_ready = !out_valid || out_ready;
   assign in_fire  = in_valid && in_ready;

   // --------------------------------------------------
   // port map lookup
   // --------------------------------------------------

   // map entry for the packet's ingress port
   assign egress_new = port_map[in_beat.meta.ingress_port];

   // later beats keep the port chosen at start of packet,
   // so a map write mid-packet cannot split it
   assign beat_egress = sop ? egress_new : egress_q;

   always_ff @(posedge core_clk) begin
      if (reset) begin
         sop       <= 1'b1;
         out_valid <= 1'b0;
      end else begin
         if (in_ready) out_valid <= in_valid;
         if (in_fire)  sop       <= in_beat.tlast;
      end
   end

   always_ff @(posedge core_clk) begin
      if (in_fire) begin
         out_beat                  <= in_beat;
         out_beat.meta.egress_port <= beat_egress;
         if (sop) egress_q <= egress_new;
      end
   end

endmodule : egress_lookup

// File: src/meta_ingress.sv
module meta_ingress
   import axis_pkg::*;
   import p4_app_pkg::*;
(
   input  logic       core_clk,
   input  logic       reset,
   input  logic       in_valid,
   input  axis_beat_t in_beat,
   output logic       in_ready,
   output logic       out_valid,
   output meta_beat_t out_beat,
   input  logic       out_ready
);

   logic           sop;
   logic           in_fire;
   user_metadata_t meta_new;
   user_metadata_t meta_q;
   user_metadata_t beat_meta;

   // output register is free or drains this cycle
   assign in_ready = !out_valid || out_ready;
   assign in_fire  = in_valid && in_ready;

   // --------------------------------------------------
   // metadata built from the first beat
   // --------------------------------------------------

   always_comb begin
      meta_new              = '0;
      meta_new.pid          = in_beat.pid;
      meta_new.ingress_port = in_beat.tid;
      // default egress is back out the ingress port
      meta_new.egress_port  = in_beat.tid;
   end

   assign beat_meta = sop ? meta_new : meta_q;

   always_ff @(posedge core_clk) begin
      if (reset) begin
         sop       <= 1'b1;
         out_valid <= 1'b0;
      end else begin
         if (in_ready) out_valid <= in_valid;
         if (in_fire)  sop       <= in_beat.tlast;
      end
   end

   // payload and latched metadata
   always_ff @(posedge core_clk) begin
      if (in_fire) begin
         out_beat.tdata <= in_beat.tdata;
         out_beat.tkeep <= in_beat.tkeep;
         out_beat.tlast <= in_beat.tlast;
         out_beat.meta  <= beat_meta;
         if (sop) meta_q <= meta_new;
      end
   end

endmodule : meta_ingress

// File: src/meta_override.sv
module meta_override
   import axis_pkg::*;
   import p4_app_pkg::*;
(
   input  logic       core_clk,
   input  logic       reset,
   input  trunc_cfg_t trunc_cfg,
   input  rss_cfg_t   rss_cfg,
   input  logic       in_valid,
   input  meta_beat_t in_beat,
   output logic       in_ready,
   output logic       out_valid,
   output axis_out_t  out_beat,
   input  logic       out_ready
);

   logic          in_fire;
   egress_tuser_t tuser;

   assign in_ready = !out_valid || out_ready;
   assign in_fire  = in_valid && in_ready;

   // --------------------------------------------------
   // register overrides, read live
   // --------------------------------------------------

   always_comb begin
      tuser.pid = in_beat.meta.pid;

      if (trunc_cfg.override_en) begin
         tuser.trunc_enable = trunc_cfg.trunc_enable;
         tuser.trunc_length = trunc_cfg.trunc_length;
      end else begin
         tuser.trunc_enable = in_beat.meta.trunc_enable;
         tuser.trunc_length = in_beat.meta.trunc_length;
      end

      // hash steering is independent of truncation
      if (rss_cfg.override_en) begin
         tuser.rss_enable  = rss_cfg.rss_enable;
         tuser.rss_entropy = rss_cfg.rss_entropy;
      end else begin
         tuser.rss_enable  = in_beat.meta.rss_enable;
         tuser.rss_entropy = in_beat.meta.rss_entropy;
      end
   end

   always_ff @(posedge core_clk) begin
      if (reset) out_valid <= 1'b0;
      else if (in_ready) out_valid <= in_valid;
   end

   // outgoing beat, held while the switch stalls
   always_ff @(posedge core_clk) begin
      if (in_fire) begin
         out_beat.tdata <= in_beat.tdata;
         out_beat.tkeep <= in_beat.tkeep;
         out_beat.tlast <= in_beat.tlast;
         out_beat.tdest <= in_beat.meta.egress_port;
         out_beat.tuser <= tuser;
      end
   end

endmodule : meta_override

// File: src/p4_app.sv
module p4_app
   import axis_pkg::*;
   import p4_app_pkg::*;
(
   input  logic        core_clk,
   input  logic        reset,

   input  reg_req_t    reg_req,
   input  logic        reg_req_valid,
   output logic        reg_ack,
   output logic [31:0] reg_rdata,

   input  logic        in_valid,
   input  axis_beat_t  in_beat,
   output logic        in_ready,
   output logic        out_valid,
   output axis_out_t   out_beat,
   input  logic        out_ready
);

   trunc_cfg_t trunc_cfg;
   rss_cfg_t   rss_cfg;
   port_map_t  port_map;

   // stage 1 to stage 2
   logic       ingress_valid;
   logic       ingress_ready;
   meta_beat_t ingress_beat;

   // stage 2 to stage 3
   logic       lookup_valid;
   logic       lookup_ready;
   meta_beat_t lookup_beat;

   // --------------------------------------------------
   // registers
   // --------------------------------------------------

   p4_app_reg_blk p4_app_reg_blk_i (
      .core_clk      (core_clk),
      .reset         (reset),
      .reg_req       (reg_req),
      .reg_req_valid (reg_req_valid),
      .reg_ack       (reg_ack),
      .reg_rdata     (reg_rdata),
      .trunc_cfg     (trunc_cfg),
      .rss_cfg       (rss_cfg),
      .port_map      (port_map)
   );

   // --------------------------------------------------
   // metadata pipeline
   // --------------------------------------------------

   meta_ingress meta_ingress_i (
      .core_clk  (core_clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .in_ready  (in_ready),
      .out_valid (ingress_valid),
      .out_beat  (ingress_beat),
      .out_ready (ingress_ready)
   );

   egress_lookup egress_lookup_i (
      .core_clk  (core_clk),
      .reset     (reset),
      .port_map  (port_map),
      .in_valid  (ingress_valid),
      .in_beat   (ingress_beat),
      .in_ready  (ingress_ready),
      .out_valid (lookup_valid),
      .out_beat  (lookup_beat),
      .out_ready (lookup_ready)
   );

   meta_override meta_override_i (
      .core_clk  (core_clk),
      .reset     (reset),
      .trunc_cfg (trunc_cfg),
      .rss_cfg   (rss_cfg),
      .in_valid  (lookup_valid),
      .in_beat   (lookup_beat),
      .in_ready  (lookup_ready),
      .out_valid (out_valid),
      .out_beat  (out_beat),
      .out_ready (out_ready)
   );

endmodule : p4_app

// File: src/p4_app_pkg.sv
package p4_app_pkg;

   import axis_pkg::*;

   localparam int NUM_PORTS = 4;

   // --------------------------------------------------
   // per-packet metadata carried through the pipeline
   // --------------------------------------------------

   typedef struct packed {
      logic [15:0] pid;
      port_id_t    ingress_port;
      port_id_t    egress_port;
      logic        trunc_enable;
      logic [15:0] trunc_length;
      logic        rss_enable;
      logic [11:0] rss_entropy;
   } user_metadata_t;

   // payload between the pipeline stages
   typedef struct packed {
      logic [63:0]    tdata;
      logic [7:0]     tkeep;
      logic           tlast;
      user_metadata_t meta;
   } meta_beat_t;

   // --------------------------------------------------
   // register map
   // --------------------------------------------------

   typedef enum logic [7:0] {
      REG_TRUNC_CFG = 8'h00,
      REG_RSS_CFG   = 8'h04,
      REG_PORT_MAP  = 8'h08
   } reg_addr_e;

   // register bits 0, 1 and 31:16
   typedef struct packed {
      logic        override_en;
      logic        trunc_enable;
      logic [15:0] trunc_length;
   } trunc_cfg_t;

   // register bits 0, 1 and 27:16
   typedef struct packed {
      logic        override_en;
      logic        rss_enable;
      logic [11:0] rss_entropy;
   } rss_cfg_t;

   // entry i sits in register bits 2i+1:2i
   typedef port_id_t [NUM_PORTS-1:0] port_map_t;

   // identity map, entry i sends to port i
   localparam port_map_t PORT_MAP_RESET = {2'd3, 2'd2, 2'd1, 2'd0};

   typedef struct packed {
      logic [7:0]  addr;
      logic        wr;
      logic [31:0] wdata;
   } reg_req_t;

endpackage : p4_app_pkg

// File: src/p4_app_reg_blk.sv
module p4_app_reg_blk
   import p4_app_pkg::*;
(
   input  logic        core_clk,
   input  logic        reset,
   input  reg_req_t    reg_req,
   input  logic        reg_req_valid,
   output logic        reg_ack,
   output logic [31:0] reg_rdata,
   output trunc_cfg_t  trunc_cfg,
   output rss_cfg_t    rss_cfg,
   output port_map_t   port_map
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACK,
      ST_WAIT_LOW
   } reg_state_e;

   reg_state_e  state;
   logic        req_take;
   logic [31:0] rd_mux;

   // a new request is taken only while ack is low
   assign req_take = (state == ST_IDLE) && reg_req_valid;
   assign reg_ack  = (state != ST_IDLE);

   // --------------------------------------------------
   // four-phase handshake
   // --------------------------------------------------

   always_ff @(posedge core_clk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (reg_req_valid) state <= ST_ACK;
            end
            // ack stays up until the master lets go of req
            ST_ACK, ST_WAIT_LOW: begin
               if (!reg_req_valid) state <= ST_IDLE;
               else                state <= ST_WAIT_LOW;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // --------------------------------------------------
   // register writes
   // --------------------------------------------------

   always_ff @(posedge core_clk) begin
      if (reset) begin
         trunc_cfg <= '0;
         rss_cfg   <= '0;
         port_map  <= PORT_MAP_RESET;
      end else if (req_take && reg_req.wr) begin
         case (reg_req.addr)
            REG_TRUNC_CFG: begin
               trunc_cfg.override_en  <= reg_req.wdata[0];
               trunc_cfg.trunc_enable <= reg_req.wdata[1];
               trunc_cfg.trunc_length <= reg_req.wdata[31:16];
            end
            REG_RSS_CFG: begin
               rss_cfg.override_en <= reg_req.wdata[0];
               rss_cfg.rss_enable  <= reg_req.wdata[1];
               rss_cfg.rss_entropy <= reg_req.wdata[27:16];
            end
            REG_PORT_MAP: port_map <= reg_req.wdata[7:0];
            // unknown address, acknowledged but dropped
            default: ;
         endcase
      end
   end

   // read data packing, unknown addresses read as zero
   always_comb begin
      rd_mux = '0;
      case (reg_req.addr)
         REG_TRUNC_CFG: rd_mux = {trunc_cfg.trunc_length, 14'd0,
                                  trunc_cfg.trunc_enable, trunc_cfg.override_en};
         REG_RSS_CFG:   rd_mux = {4'd0, rss_cfg.rss_entropy, 14'd0,
                                  rss_cfg.rss_enable, rss_cfg.override_en};
         REG_PORT_MAP:  rd_mux = {24'd0, port_map};
         default:       rd_mux = '0;
      endcase
   end

   // captured with the request, valid while ack is high
   always_ff @(posedge core_clk) begin
      if (req_take) reg_rdata <= rd_mux;
   end

endmodule : p4_app_reg_blk
